// File: sim.f
+incdir+.
dc_pred_pkg.sv
mb_pos_pkg.sv
edge_accum.sv
dc_combine.sv
dc_row_fill.sv
dc_pred_top.sv
dc_pred_assertions.sv
tb_dc_pred.sv

// File: Makefile
# Verilator build and run for the DC predictor testbench
# Override any variable on the command line, e.g. make run LOG=run1.log

VERILATOR ?= verilator
TOP       ?= tb_dc_pred
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TESTS PASSED" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_dc_pred.sv
// Self-checking testbench for dc_pred_top
// Expected DC values come from ref_dc using the H.264 DC rules
// Inputs change on the falling edge and outputs are sampled there too
// Pixel data is pseudo-random from a fixed-seed LCG

`timescale 1ns/1ps
`default_nettype none

`include "dc_pred_defs.svh"

module tb_dc_pred;

    import dc_pred_pkg::*;
    import mb_pos_pkg::*;

    localparam int WAIT_LIMIT  = 200;
    localparam int QUEUE_LIMIT = 1000;

    logic      clk;
    logic      rst_n;
    logic      start_i;
    mb_coord_t coord_i;
    edge_t     top_i;
    edge_t     left_i;
    row_t      row_o;
    logic      row_valid_o;
    logic      done_o;
    logic      busy_o;

    logic [31:0] lcg_state    = 32'd79313;
    pixel_t      exp_q[$];
    int          mismatch_cnt = 0;
    int          fail_cnt     = 0;
    int          sent_cnt     = 0;
    int          checked_cnt  = 0;

    dc_pred_top dc_pred_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start_i),
        .coord_i     (coord_i),
        .top_i       (top_i),
        .left_i      (left_i),
        .row_o       (row_o),
        .row_valid_o (row_valid_o),
        .done_o      (done_o),
        .busy_o      (busy_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //------------------------------------------------------------
    // Stimulus helpers
    //------------------------------------------------------------
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic edge_t random_edge();
        edge_t       e;
        logic [31:0] r;
        for (int i = 0; i < `DC_BLOCK_SIZE; i++) begin
            r    = next_rand();
            e[i] = r[23:16];
        end
        return e;
    endfunction

    // Even and odd pixels take separate values
    function automatic edge_t pattern_edge(input pixel_t even_px, input pixel_t odd_px);
        edge_t e;
        for (int i = 0; i < `DC_BLOCK_SIZE; i++) begin
            e[i] = (i % 2 == 0) ? even_px : odd_px;
        end
        return e;
    endfunction

    function automatic mb_coord_t make_coord(input int x, input int y);
        mb_coord_t c;
        c.x = x[`DC_COORD_WIDTH-1:0];
        c.y = y[`DC_COORD_WIDTH-1:0];
        return c;
    endfunction

    // Nonzero macroblock position from 1 to 64
    function automatic int rand_pos();
        logic [31:0] r;
        r = next_rand();
        return int'(r[21:16]) + 1;
    endfunction

    // Rounded mean of the available neighbour edges
    function automatic pixel_t ref_dc(input mb_coord_t c, input edge_t t, input edge_t l);
        int top_total;
        int left_total;
        int dc;
        top_total  = 0;
        left_total = 0;
        for (int i = 0; i < `DC_BLOCK_SIZE; i++) begin
            top_total  = top_total + int'(t[i]);
            left_total = left_total + int'(l[i]);
        end
        if (c.x != 0 && c.y != 0) begin
            dc = (top_total + left_total + 16) >> 5;
        end else if (c.y != 0) begin
            dc = (top_total + 8) >> 4;
        end else if (c.x != 0) begin
            dc = (left_total + 8) >> 4;
        end else begin
            dc = 128;
        end
        return pixel_t'(dc);
    endfunction

    task automatic report_counts();
        $display("errors: %0d mismatches, %0d other failures, %0d of %0d blocks checked",
                 mismatch_cnt, fail_cnt, checked_cnt, sent_cnt);
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout at %0t: %s", $time, what);
        report_counts();
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy_o && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (busy_o) begin
            abort_on_timeout("busy_o did not fall");
        end
    endtask

    // Starts one block as soon as the DUT is idle
    task automatic send_block(input mb_coord_t c, input edge_t t, input edge_t l);
        wait_idle();
        coord_i = c;
        top_i   = t;
        left_i  = l;
        start_i = 1'b1;
        exp_q.push_back(ref_dc(c, t, l));
        sent_cnt++;
        @(negedge clk);
        start_i = 1'b0;
        // Inputs are scrambled since the block was captured on the start edge
        coord_i = make_coord(rand_pos(), rand_pos());
        top_i   = random_edge();
        left_i  = random_edge();
    endtask

    // Start pulse in mid-block that the DUT must drop
    task automatic pulse_while_busy();
        repeat (4) @(negedge clk);
        assert (busy_o) else begin
            fail_cnt++;
            $display("busy_o low at %0t while a block should be running", $time);
        end
        coord_i = make_coord(0, 0);
        top_i   = random_edge();
        left_i  = random_edge();
        start_i = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
    endtask

    //------------------------------------------------------------
    // Driver
    //------------------------------------------------------------
    initial begin : drive_blocks
        int n;
        rst_n   = 1'b1;
        start_i = 1'b0;
        coord_i = '0;
        top_i   = '0;
        left_i  = '0;
        #1 rst_n = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        assert (!row_valid_o && !done_o && !busy_o && row_o == '0) else begin
            fail_cnt++;
            $display("outputs not quiet after reset at %0t", $time);
        end

        // Both edges, then single edges, then none
        repeat (8) send_block(make_coord(rand_pos(), rand_pos()), random_edge(), random_edge());
        repeat (4) send_block(make_coord(0, rand_pos()), random_edge(), random_edge());
        repeat (4) send_block(make_coord(rand_pos(), 0), random_edge(), random_edge());
        repeat (3) send_block(make_coord(0, 0), random_edge(), random_edge());

        // Extremes and exact rounding ties
        send_block(make_coord(3, 5), pattern_edge(0, 0), pattern_edge(0, 0));
        send_block(make_coord(3, 5), pattern_edge(255, 255), pattern_edge(255, 255));
        send_block(make_coord(0, 2), pattern_edge(255, 255), pattern_edge(0, 0));
        send_block(make_coord(2, 0), pattern_edge(0, 0), pattern_edge(255, 255));
        send_block(make_coord(1, 1), pattern_edge(0, 255), pattern_edge(255, 0));
        send_block(make_coord(1, 1), pattern_edge(1, 1), pattern_edge(0, 0));
        send_block(make_coord(0, 1), pattern_edge(1, 0), pattern_edge(9, 9));
        send_block(make_coord(1, 0), pattern_edge(7, 7), pattern_edge(0, 255));

        // Ignored starts between back-to-back blocks
        send_block(make_coord(rand_pos(), rand_pos()), random_edge(), random_edge());
        pulse_while_busy();
        send_block(make_coord(0, rand_pos()), random_edge(), random_edge());
        pulse_while_busy();
        repeat (3) send_block(make_coord(rand_pos(), rand_pos()), random_edge(), random_edge());

        n = 0;
        while (checked_cnt < sent_cnt && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (checked_cnt < sent_cnt) begin
            abort_on_timeout("not every block produced its rows");
        end else begin
            report_counts();
            if (mismatch_cnt == 0 && fail_cnt == 0) begin
                $display("TESTS PASSED");
            end else begin
                $display("TESTS FAILED");
            end
            $finish;
        end
    end

    //------------------------------------------------------------
    // Comparing process
    //------------------------------------------------------------
    initial begin : compare_rows
        pixel_t exp_dc;
        row_t   exp_row;
        int     n;
        forever begin
            n = 0;
            while (exp_q.size() == 0 && n < QUEUE_LIMIT) begin
                @(negedge clk);
                assert (!row_valid_o) else begin
                    fail_cnt++;
                    $display("row strobe at %0t with no block started", $time);
                end
                n++;
            end
            if (exp_q.size() == 0) begin
                abort_on_timeout("no block reached the checker");
            end else begin
                exp_dc  = exp_q.pop_front();
                exp_row = {`DC_BLOCK_SIZE{exp_dc}};

                n = 0;
                while (!row_valid_o && n < WAIT_LIMIT) begin
                    @(negedge clk);
                    n++;
                end
                if (!row_valid_o) begin
                    abort_on_timeout("row_valid_o did not rise");
                end else begin
                    for (int r = 0; r < `DC_BLOCK_SIZE; r++) begin
                        assert (row_valid_o) else begin
                            fail_cnt++;
                            $display("row_valid_o dropped at row %0d, time %0t", r, $time);
                        end
                        assert (row_o == exp_row) else begin
                            mismatch_cnt++;
                            $display("mismatch at %0t: row %0d expected dc %0d, got row %h",
                                     $time, r, exp_dc, row_o);
                        end
                        assert (done_o == (r == `DC_BLOCK_SIZE - 1)) else begin
                            fail_cnt++;
                            $display("done_o wrong on row %0d at %0t", r, $time);
                        end
                        @(negedge clk);
                    end
                    assert (!row_valid_o) else begin
                        fail_cnt++;
                        $display("more than %0d row strobes at %0t", `DC_BLOCK_SIZE, $time);
                    end
                    assert (!busy_o) else begin
                        fail_cnt++;
                        $display("busy_o still high after the last row at %0t", $time);
                    end
                    checked_cnt++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: dc_pred_assertions.sv
// Protocol checks bound into dc_pred_top
// A row burst must last exactly DC_BLOCK_SIZE cycles
// Quiet outputs are checked on every clock edge during the asynchronous reset

`timescale 1ns/1ps
`default_nettype none

`include "dc_pred_defs.svh"

module dc_pred_assertions (
    input wire               clk,
    input wire               rst_n,
    input dc_pred_pkg::row_t row_o,
    input wire               row_valid_o,
    input wire               done_o,
    input wire               busy_o
);

    // Length of the current row burst
    logic [5:0] run_len;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_len <= '0;
        end else if (row_valid_o) begin
            run_len <= run_len + 6'd1;
        end else begin
            run_len <= '0;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        row_valid_o |-> run_len < 6'(`DC_BLOCK_SIZE))
        else $error("row_valid_o high for too many cycles");

    assert property (@(posedge clk) disable iff (!rst_n)
        $fell(row_valid_o) |-> run_len == 6'(`DC_BLOCK_SIZE))
        else $error("row burst shorter than one block");

    // Done marks the last row of a burst
    assert property (@(posedge clk) disable iff (!rst_n)
        done_o |-> row_valid_o && run_len == 6'(`DC_BLOCK_SIZE - 1))
        else $error("done_o outside the last row of a burst");

    assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy_o) |-> $past(done_o))
        else $error("busy_o fell without done_o");

    // Outputs held quiet through reset
    assert property (@(posedge clk)
        !rst_n |-> (!row_valid_o && !done_o && !busy_o && row_o == '0))
        else $error("outputs active during reset");

endmodule

bind dc_pred_top dc_pred_assertions u_assertions (
    .clk         (clk),
    .rst_n       (rst_n),
    .row_o       (row_o),
    .row_valid_o (row_valid_o),
    .done_o      (done_o),
    .busy_o      (busy_o)
);

`default_nettype wire

// File: dc_pred_top.sv
// DC intra predictor for one 16x16 luma block at a time
// start_i is a one-cycle pulse, ignored while busy_o is high
// Rows come out 6 cycles after acceptance, the consumer takes every row
// Neighbour availability follows picture borders only

`timescale 1ns/1ps
`default_nettype none

`include "dc_pred_defs.svh"

module dc_pred_top (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   start_i,
    input  mb_pos_pkg::mb_coord_t coord_i,
    input  dc_pred_pkg::edge_t    top_i,
    input  dc_pred_pkg::edge_t    left_i,
    output dc_pred_pkg::row_t     row_o,
    output logic                  row_valid_o,
    output logic                  done_o,
    output logic                  busy_o
);

    import dc_pred_pkg::*;
    import mb_pos_pkg::*;

    logic      accept;
    logic      busy_q;
    avail_t    avail_q;
    edge_sum_t top_sum;
    edge_sum_t left_sum;
    pixel_t    dc_value;
    logic      dc_valid;

    assign accept = start_i && !busy_q;

    //------------------------------------------------------------
    // Block control
    //------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q  <= 1'b0;
            avail_q <= '0;
        end else if (accept) begin
            busy_q       <= 1'b1;
            // Column zero has no left block, row zero no top block
            avail_q.left <= (coord_i.x != '0);
            avail_q.top  <= (coord_i.y != '0);
        end else if (done_o) begin
            busy_q <= 1'b0;
        end
    end

    assign busy_o = busy_q;

    //------------------------------------------------------------
    // Datapath
    //------------------------------------------------------------
    edge_accum u_top_accum (
        .clk    (clk),
        .rst_n  (rst_n),
        .load_i (accept),
        .edge_i (top_i),
        .sum_o  (top_sum)
    );

    edge_accum u_left_accum (
        .clk    (clk),
        .rst_n  (rst_n),
        .load_i (accept),
        .edge_i (left_i),
        .sum_o  (left_sum)
    );

    dc_combine u_combine (
        .clk        (clk),
        .rst_n      (rst_n),
        .avail_i    (avail_q),
        .top_sum_i  (top_sum),
        .left_sum_i (left_sum),
        .dc_o       (dc_value),
        .dc_valid_o (dc_valid)
    );

    dc_row_fill u_row_fill (
        .clk         (clk),
        .rst_n       (rst_n),
        .dc_i        (dc_value),
        .dc_valid_i  (dc_valid),
        .row_o       (row_o),
        .row_valid_o (row_valid_o),
        .done_o      (done_o)
    );

endmodule

`default_nettype wire

// File: dc_row_fill.sv
// Emits DC_BLOCK_SIZE rows, each the DC value in every pixel
// No back-pressure, one row per cycle once started
// dc_valid_i during an active block restarts the count

`timescale 1ns/1ps
`default_nettype none

`include "dc_pred_defs.svh"

module dc_row_fill (
    input  wire                 clk,
    input  wire                 rst_n,
    input  dc_pred_pkg::pixel_t dc_i,
    input  wire                 dc_valid_i,
    output dc_pred_pkg::row_t   row_o,
    output logic                row_valid_o,
    output logic                done_o
);

    import dc_pred_pkg::*;

    localparam int ROW_W = $clog2(`DC_BLOCK_SIZE);

    pixel_t           dc_q;
    logic [ROW_W-1:0] row_q;
    logic             active_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dc_q     <= '0;
            row_q    <= '0;
            active_q <= 1'b0;
        end else if (dc_valid_i) begin
            dc_q     <= dc_i;
            row_q    <= '0;
            active_q <= 1'b1;
        end else if (active_q) begin
            // Back to idle after the last row
            if (row_q == ROW_W'(`DC_BLOCK_SIZE - 1)) begin
                active_q <= 1'b0;
            end else begin
                row_q <= row_q + 1'b1;
            end
        end
    end

    // Same value across the whole row
    assign row_o       = {`DC_BLOCK_SIZE{dc_q}};
    assign row_valid_o = active_q;
    assign done_o      = active_q && (row_q == ROW_W'(`DC_BLOCK_SIZE - 1));

endmodule

`default_nettype wire

// File: dc_combine.sv
// Selects the DC rule from edge availability and registers the mean
// Both sum strobes are expected on the same cycle
// Availability must stay stable while the sums are in flight

`timescale 1ns/1ps
`default_nettype none

`include "dc_pred_defs.svh"

module dc_combine (
    input  wire                    clk,
    input  wire                    rst_n,
    input  mb_pos_pkg::avail_t     avail_i,
    input  dc_pred_pkg::edge_sum_t top_sum_i,
    input  dc_pred_pkg::edge_sum_t left_sum_i,
    output dc_pred_pkg::pixel_t    dc_o,
    output logic                   dc_valid_o
);

    import dc_pred_pkg::*;

    // One extra bit for the two-edge total
    localparam int TOT_W = DC_SUM_WIDTH + 1;

    logic [TOT_W-1:0] both_rnd;
    logic [TOT_W-1:0] top_rnd;
    logic [TOT_W-1:0] left_rnd;
    logic             sums_valid;
    pixel_t           mean;
    pixel_t           dc_q;
    logic             dc_valid_q;

    assign sums_valid = top_sum_i.valid & left_sum_i.valid;

    // Rounding offsets: half of the divisor
    assign both_rnd = TOT_W'(top_sum_i.sum) + TOT_W'(left_sum_i.sum) + TOT_W'(16);
    assign top_rnd  = TOT_W'(top_sum_i.sum) + TOT_W'(8);
    assign left_rnd = TOT_W'(left_sum_i.sum) + TOT_W'(8);

    //------------------------------------------------------------
    // Rule select
    //------------------------------------------------------------
    always_comb begin
        unique case ({avail_i.top, avail_i.left})
            2'b11:   mean = pixel_t'(both_rnd >> 5);
            2'b10:   mean = pixel_t'(top_rnd >> 4);
            2'b01:   mean = pixel_t'(left_rnd >> 4);
            default: mean = pixel_t'(1 << (`DC_BIT_WIDTH - 1));
        endcase
    end

    // Mean register, payload only
    always_ff @(posedge clk) begin
        if (sums_valid) begin
            dc_q <= mean;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dc_valid_q <= 1'b0;
        end else begin
            dc_valid_q <= sums_valid;
        end
    end

    assign dc_o       = dc_q;
    assign dc_valid_o = dc_valid_q;

endmodule

`default_nettype wire

// File: edge_accum.sv
// Sums one neighbour edge, DC_LANES pixels per cycle
// load_i must not arrive while a sum is in progress
// Fixed latency: strobe rises DC_BLOCK_SIZE/DC_LANES edges after load

`timescale 1ns/1ps
`default_nettype none

`include "dc_pred_defs.svh"

module edge_accum (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   load_i,
    input  dc_pred_pkg::edge_t    edge_i,
    output dc_pred_pkg::edge_sum_t sum_o
);

    import dc_pred_pkg::*;

    localparam int STEPS   = `DC_BLOCK_SIZE / `DC_LANES;
    localparam int CNT_W   = (STEPS > 1) ? $clog2(STEPS) : 1;

    edge_t                   shift_q;
    logic [DC_SUM_WIDTH-1:0] acc_q;
    logic [DC_SUM_WIDTH-1:0] lane_sum;
    logic [CNT_W-1:0]        step_q;
    logic                    active_q;
    logic                    valid_q;

    // Adder tree over the low lanes of the shift register
    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < `DC_LANES; i++) begin
            lane_sum = lane_sum + DC_SUM_WIDTH'(shift_q[i]);
        end
    end

    // Edge pixels, consumed from the low end
    always_ff @(posedge clk) begin
        if (load_i) begin
            shift_q <= edge_i;
        end else if (active_q) begin
            shift_q <= shift_q >> (`DC_LANES * `DC_BIT_WIDTH);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q    <= '0;
            step_q   <= '0;
            active_q <= 1'b0;
            valid_q  <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            if (load_i) begin
                acc_q    <= '0;
                step_q   <= '0;
                active_q <= 1'b1;
            end else if (active_q) begin
                acc_q  <= acc_q + lane_sum;
                step_q <= step_q + 1'b1;
                // Last group of lanes
                if (step_q == CNT_W'(STEPS - 1)) begin
                    active_q <= 1'b0;
                    valid_q  <= 1'b1;
                end
            end
        end
    end

    assign sum_o.sum   = acc_q;
    assign sum_o.valid = valid_q;

endmodule

`default_nettype wire

// File: mb_pos_pkg.sv
// Macroblock position types
// Coordinates count macroblocks, not pixels
// Availability covers picture edges only, no slice rules

`default_nettype none

`include "dc_pred_defs.svh"

package mb_pos_pkg;

    // Macroblock column and row
    typedef struct packed {
        logic [`DC_COORD_WIDTH-1:0] x;
        logic [`DC_COORD_WIDTH-1:0] y;
    } mb_coord_t;

    // Neighbour edges that may be used for prediction
    typedef struct packed {
        logic top;
        logic left;
    } avail_t;

endpackage

`default_nettype wire

// File: dc_pred_pkg.sv
// Datapath types for the DC predictor
// Pixel 0 of an edge or row sits in the low bits of the packed array
// The edge sum width covers DC_BLOCK_SIZE full-scale pixels

`default_nettype none

`include "dc_pred_defs.svh"

package dc_pred_pkg;

    // Width of a single-edge sum, 16 x 255 = 4080
    localparam int DC_SUM_WIDTH = 12;

    // One luma sample
    typedef logic [`DC_BIT_WIDTH-1:0] pixel_t;

    // Sixteen neighbour pixels of one edge
    typedef pixel_t [`DC_BLOCK_SIZE-1:0] edge_t;

    // One predicted output row, same layout as an edge
    typedef pixel_t [`DC_BLOCK_SIZE-1:0] row_t;

    // Edge total with its one-cycle strobe
    typedef struct packed {
        logic [DC_SUM_WIDTH-1:0] sum;
        logic                    valid;
    } edge_sum_t;

endpackage

`default_nettype wire

// File: dc_pred_defs.svh
// Sizing macros for the 16x16 luma DC predictor
// DC_BLOCK_SIZE must be a multiple of DC_LANES
// Edge sums are held in 12 bits, enough for 16 pixels of 8 bits only

`ifndef DC_PRED_DEFS_SVH
`define DC_PRED_DEFS_SVH

// Bits per luma sample
`define DC_BIT_WIDTH    8

// Pixels per edge and rows per block
`define DC_BLOCK_SIZE   16

// Pixels summed per accumulator cycle
`define DC_LANES        4

// Width of each macroblock coordinate
`define DC_COORD_WIDTH  10

`endif
